// ==== hdl/rv_isa_pkg.sv ====
package rv_isa_pkg;

  typedef logic [31:0] inst_t;

  // major opcodes handled by this slice.
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // funct7 bit 5 on top of funct3.
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_cond_e;

  function automatic logic [31:0] imm_i(inst_t inst);
    return {{20{inst[31]}}, inst[31:20]};
  endfunction

  function automatic logic [31:0] imm_u(inst_t inst);
    return {inst[31:12], 12'b0};
  endfunction

  function automatic logic [31:0] imm_j(inst_t inst);
    return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

  function automatic logic [31:0] imm_b(inst_t inst);
    return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  endfunction

endpackage

// ==== hdl/pipe_pkg.sv ====
package pipe_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 16;
  localparam int REG_AW   = 4;

  typedef enum logic [1:0] {
    KIND_ALU    = 2'd0,
    KIND_JUMP   = 2'd1,
    KIND_BRANCH = 2'd2
  } kind_e;

  typedef struct packed {
    rv_isa_pkg::inst_t inst;
    logic [XLEN-1:0]   pc;
  } fetch_t;

  // for jumps op1 is the target base and op2 holds the link increment.
  typedef struct packed {
    logic [XLEN-1:0]      pc;
    logic [XLEN-1:0]      op1;
    logic [XLEN-1:0]      op2;
    logic [XLEN-1:0]      imm;
    logic [REG_AW-1:0]    rd;
    logic                 we;
    rv_isa_pkg::alu_op_e  alu_op;
    kind_e                kind;
    rv_isa_pkg::br_cond_e br_cond;
    logic                 illegal;
  } issue_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] rd;
    logic              we;
    logic [XLEN-1:0]   value;
    logic              redirect;
    logic [XLEN-1:0]   target;
    logic              illegal;
  } result_t;

endpackage

// ==== hdl/inst_decode.sv ====
module inst_decode
  import rv_isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                in_valid_i,
  input  fetch_t              in_i,
  output logic                in_ready_o,
  output logic [REG_AW-1:0]   raddr1_o,
  output logic [REG_AW-1:0]   raddr2_o,
  input  logic [XLEN-1:0]     rdata1_i,
  input  logic [XLEN-1:0]     rdata2_i,
  input  logic [NUM_REGS-1:0] pending_i,
  input  logic                fwd_valid_i,
  input  logic [REG_AW-1:0]   fwd_rd_i,
  input  logic [XLEN-1:0]     fwd_value_i,
  output logic                issue_valid_o,
  output issue_t              issue_o
);

  fetch_t            fetch_q;
  logic              valid_q;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [REG_AW-1:0] rd;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic              uses_rs1;
  logic              uses_rs2;
  logic              fwd1;
  logic              fwd2;
  logic [XLEN-1:0]   src1;
  logic [XLEN-1:0]   src2;
  logic              hazard;
  issue_t            issue;

  // rv32e only has sixteen registers, so the top bit of each field is dropped.
  assign rs1    = fetch_q.inst[15 +: REG_AW];
  assign rs2    = fetch_q.inst[20 +: REG_AW];
  assign rd     = fetch_q.inst[7 +: REG_AW];
  assign funct3 = fetch_q.inst[14:12];
  assign funct7 = fetch_q.inst[31:25];

  assign raddr1_o = rs1;
  assign raddr2_o = rs2;

  // x0 is never forwarded because its value is always zero.
  assign fwd1 = fwd_valid_i && (fwd_rd_i == rs1) && (rs1 != '0);
  assign fwd2 = fwd_valid_i && (fwd_rd_i == rs2) && (rs2 != '0);
  assign src1 = fwd1 ? fwd_value_i : rdata1_i;
  assign src2 = fwd2 ? fwd_value_i : rdata2_i;

  // a producer in execute is covered by forwarding but one in writeback is not.
  assign hazard = valid_q && (
    (uses_rs1 && (rs1 != '0) && pending_i[rs1] && !fwd1) ||
    (uses_rs2 && (rs2 != '0) && pending_i[rs2] && !fwd2));

  assign issue_valid_o = valid_q && !hazard;
  assign in_ready_o    = !valid_q || issue_valid_o;
  assign issue_o       = issue;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      valid_q <= 1'b1;
    end else if (issue_valid_o) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      fetch_q <= in_i;
    end
  end

  always_comb begin
    issue         = '0;
    issue.pc      = fetch_q.pc;
    issue.rd      = rd;
    issue.alu_op  = ALU_ADD;
    issue.kind    = KIND_ALU;
    issue.br_cond = BR_BEQ;
    uses_rs1      = 1'b0;
    uses_rs2      = 1'b0;
    case (fetch_q.inst[6:0])
      OPC_LUI: begin
        issue.op2 = imm_u(fetch_q.inst);
        issue.imm = imm_u(fetch_q.inst);
        issue.we  = 1'b1;
      end
      OPC_AUIPC: begin
        issue.op1 = fetch_q.pc;
        issue.op2 = imm_u(fetch_q.inst);
        issue.imm = imm_u(fetch_q.inst);
        issue.we  = 1'b1;
      end
      OPC_JAL: begin
        issue.kind = KIND_JUMP;
        issue.op1  = fetch_q.pc;
        issue.op2  = 32'd4;
        issue.imm  = imm_j(fetch_q.inst);
        issue.we   = 1'b1;
      end
      OPC_JALR: begin
        uses_rs1   = 1'b1;
        issue.kind = KIND_JUMP;
        issue.op1  = src1;
        issue.op2  = 32'd4;
        issue.imm  = imm_i(fetch_q.inst);
        issue.we   = 1'b1;
      end
      OPC_BRANCH: begin
        uses_rs1      = 1'b1;
        uses_rs2      = 1'b1;
        issue.kind    = KIND_BRANCH;
        issue.op1     = src1;
        issue.op2     = src2;
        issue.imm     = imm_b(fetch_q.inst);
        issue.br_cond = br_cond_e'(funct3);
      end
      OPC_OP_IMM: begin
        uses_rs1     = 1'b1;
        issue.op1    = src1;
        issue.op2    = imm_i(fetch_q.inst);
        issue.imm    = imm_i(fetch_q.inst);
        issue.alu_op = alu_op_e'({(funct3 == 3'b101) && funct7[5], funct3});
        issue.we     = 1'b1;
      end
      OPC_OP: begin
        uses_rs1     = 1'b1;
        uses_rs2     = 1'b1;
        issue.op1    = src1;
        issue.op2    = src2;
        // only add and shift-right have an alternate form.
        issue.alu_op = alu_op_e'({((funct3 == 3'b000) || (funct3 == 3'b101)) && funct7[5],
                                  funct3});
        issue.we     = 1'b1;
      end
      default: begin
        issue.illegal = 1'b1;
      end
    endcase
  end

  // a stalled instruction stays in place and is not lost.
  a_stall_holds: assert property (@(posedge clk_i) disable iff (rst_i)
    hazard |=> valid_q);

  a_stall_no_accept: assert property (@(posedge clk_i) disable iff (rst_i)
    (hazard && in_valid_i) |=> $stable(fetch_q));

endmodule

// ==== hdl/alu_exec.sv ====
module alu_exec
  import rv_isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              issue_valid_i,
  input  issue_t            issue_i,
  output logic              fwd_valid_o,
  output logic [REG_AW-1:0] fwd_rd_o,
  output logic [XLEN-1:0]   fwd_value_o,
  output logic              res_valid_o,
  output result_t           res_o
);

  issue_t          issue_q;
  logic            valid_q;
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] tgt_base;
  logic [XLEN-1:0] tgt_sum;
  logic            taken;
  result_t         res;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    issue_q <= issue_i;
  end

  // the link is pc plus four, so jumps feed the pc into the adder.
  assign alu_a = (issue_q.kind == KIND_JUMP) ? issue_q.pc : issue_q.op1;
  assign alu_b = issue_q.op2;

  always_comb begin
    case (issue_q.alu_op)
      ALU_ADD:  alu_res = alu_a + alu_b;
      ALU_SUB:  alu_res = alu_a - alu_b;
      ALU_SLL:  alu_res = alu_a << alu_b[4:0];
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, alu_a < alu_b};
      ALU_XOR:  alu_res = alu_a ^ alu_b;
      ALU_SRL:  alu_res = alu_a >> alu_b[4:0];
      ALU_SRA:  alu_res = $signed(alu_a) >>> alu_b[4:0];
      ALU_OR:   alu_res = alu_a | alu_b;
      ALU_AND:  alu_res = alu_a & alu_b;
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    case (issue_q.br_cond)
      BR_BEQ:  taken = issue_q.op1 == issue_q.op2;
      BR_BNE:  taken = issue_q.op1 != issue_q.op2;
      BR_BLT:  taken = $signed(issue_q.op1) < $signed(issue_q.op2);
      BR_BGE:  taken = $signed(issue_q.op1) >= $signed(issue_q.op2);
      BR_BLTU: taken = issue_q.op1 < issue_q.op2;
      BR_BGEU: taken = issue_q.op1 >= issue_q.op2;
      default: taken = 1'b0;
    endcase
  end

  assign tgt_base = (issue_q.kind == KIND_BRANCH) ? issue_q.pc : issue_q.op1;
  assign tgt_sum  = tgt_base + issue_q.imm;

  always_comb begin
    res          = '0;
    res.pc       = issue_q.pc;
    res.rd       = issue_q.rd;
    res.we       = issue_q.we && !issue_q.illegal;
    res.illegal  = issue_q.illegal;
    res.value    = (issue_q.kind == KIND_BRANCH) ? '0 : alu_res;
    res.redirect = !issue_q.illegal && ((issue_q.kind == KIND_JUMP) ||
                                        ((issue_q.kind == KIND_BRANCH) && taken));
    // jal targets are already even, clearing bit 0 matters for jalr.
    if (issue_q.kind == KIND_JUMP) begin
      res.target = {tgt_sum[XLEN-1:1], 1'b0};
    end else if (issue_q.kind == KIND_BRANCH) begin
      res.target = tgt_sum;
    end
  end

  assign fwd_valid_o = valid_q && res.we;
  assign fwd_rd_o    = issue_q.rd;
  assign fwd_value_o = res.value;
  assign res_valid_o = valid_q;
  assign res_o       = res;

  a_branch_no_write: assert property (@(posedge clk_i) disable iff (rst_i)
    (issue_valid_i && (issue_i.kind == KIND_BRANCH)) |=> (res_valid_o && !res_o.we));

endmodule

// ==== hdl/reg_writeback.sv ====
module reg_writeback
  import pipe_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic [REG_AW-1:0]   raddr1_i,
  input  logic [REG_AW-1:0]   raddr2_i,
  output logic [XLEN-1:0]     rdata1_o,
  output logic [XLEN-1:0]     rdata2_o,
  output logic [NUM_REGS-1:0] pending_o,
  input  logic                issue_strobe_i,
  input  logic [REG_AW-1:0]   issue_rd_i,
  input  logic                res_valid_i,
  input  result_t             res_i,
  output logic                result_valid_o,
  output result_t             result_o
);

  result_t         res_q;
  logic            valid_q;
  logic            wr_en;
  logic [XLEN-1:0] rf [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= res_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    res_q <= res_i;
  end

  // the write lands on the edge that ends the result strobe.
  assign wr_en = valid_q && res_q.we;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        rf[i] <= '0;
      end
    end else if (wr_en && (res_q.rd != '0)) begin
      rf[res_q.rd] <= res_q.value;
    end
  end

  assign rdata1_o = rf[raddr1_i];
  assign rdata2_o = rf[raddr2_i];

  for (genvar r = 0; r < NUM_REGS; r++) begin : g_pend
    logic [1:0] cnt_q;
    logic       inc;
    logic       dec;

    assign inc = issue_strobe_i && (issue_rd_i == REG_AW'(r));
    assign dec = wr_en && (res_q.rd == REG_AW'(r));

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        cnt_q <= 2'd0;
      end else if (inc && !dec) begin
        cnt_q <= cnt_q + 2'd1;
      end else if (dec && !inc) begin
        cnt_q <= cnt_q - 2'd1;
      end
    end

    assign pending_o[r] = cnt_q != 2'd0;

    // every write back must have been counted at issue.
    a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
      dec |-> (cnt_q != 2'd0));
  end

  assign result_valid_o = valid_q;
  assign result_o       = res_q;

endmodule

// ==== hdl/core_slice_top.sv ====
module core_slice_top
  import pipe_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid_i,
  input  fetch_t  in_i,
  output logic    in_ready_o,
  output logic    result_valid_o,
  output result_t result_o
);

  logic                issue_valid;
  issue_t              issue;
  logic [REG_AW-1:0]   raddr1;
  logic [REG_AW-1:0]   raddr2;
  logic [XLEN-1:0]     rdata1;
  logic [XLEN-1:0]     rdata2;
  logic [NUM_REGS-1:0] pending;
  logic                fwd_valid;
  logic [REG_AW-1:0]   fwd_rd;
  logic [XLEN-1:0]     fwd_value;
  logic                res_valid;
  result_t             res;

  inst_decode u_decode (
    .clk_i         (clk),
    .rst_i         (rst),
    .in_valid_i    (in_valid_i),
    .in_i          (in_i),
    .in_ready_o    (in_ready_o),
    .raddr1_o      (raddr1),
    .raddr2_o      (raddr2),
    .rdata1_i      (rdata1),
    .rdata2_i      (rdata2),
    .pending_i     (pending),
    .fwd_valid_i   (fwd_valid),
    .fwd_rd_i      (fwd_rd),
    .fwd_value_i   (fwd_value),
    .issue_valid_o (issue_valid),
    .issue_o       (issue)
  );

  alu_exec u_exec (
    .clk_i         (clk),
    .rst_i         (rst),
    .issue_valid_i (issue_valid),
    .issue_i       (issue),
    .fwd_valid_o   (fwd_valid),
    .fwd_rd_o      (fwd_rd),
    .fwd_value_o   (fwd_value),
    .res_valid_o   (res_valid),
    .res_o         (res)
  );

  // the scoreboard counts only instructions that will write back.
  reg_writeback u_writeback (
    .clk_i          (clk),
    .rst_i          (rst),
    .raddr1_i       (raddr1),
    .raddr2_i       (raddr2),
    .rdata1_o       (rdata1),
    .rdata2_o       (rdata2),
    .pending_o      (pending),
    .issue_strobe_i (issue_valid && issue.we),
    .issue_rd_i     (issue.rd),
    .res_valid_i    (res_valid),
    .res_i          (res),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

endmodule

// ==== verif/core_slice_tb.sv ====
module core_slice_tb
  import rv_isa_pkg::*;
  import pipe_pkg::*;
();

  localparam int NUM_DIRECTED = 5;
  localparam int NUM_RANDOM   = 400;
  localparam int NUM_TOTAL    = NUM_DIRECTED + NUM_RANDOM;
  localparam int CYCLE_LIMIT  = 3 * NUM_TOTAL + 100;

  logic    clk;
  logic    rst;
  logic    in_valid_i;
  fetch_t  in_i;
  logic    in_ready_o;
  logic    result_valid_o;
  result_t result_o;

  logic [31:0] lfsr_q = 32'h6906_2df0;
  logic [31:0] model_rf [NUM_REGS];
  result_t     want_q [$];
  int          cycles = 0;
  int          accepted = 0;
  int          results_checked = 0;
  int          first_accept_cycle = 0;

  core_slice_top uut (
    .clk            (clk),
    .rst            (rst),
    .in_valid_i     (in_valid_i),
    .in_i           (in_i),
    .in_ready_o     (in_ready_o),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      abort_run($sformatf("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  function automatic fetch_t make_fetch(input logic [31:0] inst, input logic [31:0] pc);
    fetch_t f;
    f.inst = inst;
    f.pc   = pc;
    return f;
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input opcode_e opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input opcode_e opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic is_slice_opcode(input logic [6:0] opc);
    return opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_OP_IMM, OPC_OP};
  endfunction

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b011:  return {31'd0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // in-order reference model, run once per accepted instruction.
  task automatic model_step(input fetch_t f, output result_t want);
    logic [31:0] inst;
    logic [3:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_iv;
    logic        taken;
    inst   = f.inst;
    rd     = inst[10:7];
    a      = model_rf[inst[18:15]];
    b      = model_rf[inst[23:20]];
    imm_iv = {{20{inst[31]}}, inst[31:20]};
    taken  = 1'b0;
    want    = '0;
    want.pc = f.pc;
    want.rd = rd;
    case (inst[6:0])
      OPC_LUI: begin
        want.we    = 1'b1;
        want.value = {inst[31:12], 12'd0};
      end
      OPC_AUIPC: begin
        want.we    = 1'b1;
        want.value = f.pc + {inst[31:12], 12'd0};
      end
      OPC_JAL: begin
        want.we       = 1'b1;
        want.value    = f.pc + 32'd4;
        want.redirect = 1'b1;
        want.target   = f.pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      OPC_JALR: begin
        want.we       = 1'b1;
        want.value    = f.pc + 32'd4;
        want.redirect = 1'b1;
        want.target   = (a + imm_iv) & ~32'd1;
      end
      OPC_BRANCH: begin
        case (inst[14:12])
          3'b000:  taken = a == b;
          3'b001:  taken = a != b;
          3'b100:  taken = $signed(a) < $signed(b);
          3'b101:  taken = $signed(a) >= $signed(b);
          3'b110:  taken = a < b;
          3'b111:  taken = a >= b;
          default: taken = 1'b0;
        endcase
        want.redirect = taken;
        want.target   = f.pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      OPC_OP_IMM: begin
        want.we    = 1'b1;
        want.value = alu_model(inst[14:12], (inst[14:12] == 3'b101) && inst[30], a, imm_iv);
      end
      OPC_OP: begin
        want.we    = 1'b1;
        want.value = alu_model(inst[14:12], inst[30], a, b);
      end
      default: begin
        want.illegal = 1'b1;
      end
    endcase
    if (want.we && (rd != 4'd0)) begin
      model_rf[rd] = want.value;
    end
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      abort_run($sformatf("** Error at time %0t: %s is 0x%08h, expected 0x%08h",
                          $time, name, got, want));
    end
  endtask

  task automatic compare_result(input result_t got, input result_t want);
    check_field("result_o.pc", got.pc, want.pc);
    check_field("result_o.rd", 32'(got.rd), 32'(want.rd));
    check_field("result_o.we", 32'(got.we), 32'(want.we));
    check_field("result_o.value", got.value, want.value);
    check_field("result_o.redirect", 32'(got.redirect), 32'(want.redirect));
    check_field("result_o.target", got.target, want.target);
    check_field("result_o.illegal", 32'(got.illegal), 32'(want.illegal));
  endtask

  task automatic compare_ready(input logic want);
    if (in_ready_o !== want) begin
      abort_run($sformatf("** Error at time %0t: in_ready_o is %b, expected %b",
                          $time, in_ready_o, want));
    end
  endtask

  always @(negedge clk) begin
    result_t want;
    if (!rst) begin
      if (result_valid_o) begin
        if (want_q.size() == 0) begin
          abort_run("a result strobe came with no instruction outstanding");
        end else if ((results_checked == 0) && (cycles - first_accept_cycle != 3)) begin
          abort_run($sformatf("first result came %0d cycles after acceptance instead of 3",
                              cycles - first_accept_cycle));
        end else begin
          want = want_q.pop_front();
          compare_result(result_o, want);
          results_checked++;
        end
      end
      if (in_valid_i && in_ready_o) begin
        if (accepted == 0) begin
          first_accept_cycle = cycles;
        end
        model_step(in_i, want);
        want_q.push_back(want);
        accepted++;
      end
    end
  end

  task automatic drive_inst(input fetch_t f);
    in_valid_i <= 1'b1;
    in_i       <= f;
    @(negedge clk);
    while (!in_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic drive_idle();
    in_valid_i <= 1'b0;
    @(posedge clk);
  endtask

  // register numbers come from x0..x7 so that dependences are frequent.
  task automatic gen_inst(output fetch_t f);
    logic [2:0]  cls;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm12;
    logic [6:0]  opc;
    cls   = 3'(rand_bits(3));
    rd    = {2'b00, 3'(rand_bits(3))};
    rs1   = {2'b00, 3'(rand_bits(3))};
    rs2   = {2'b00, 3'(rand_bits(3))};
    f3    = 3'(rand_bits(3));
    alt   = 1'(rand_bits(1));
    imm12 = 12'(rand_bits(12));
    f.pc  = {30'(rand_bits(30)), 2'b00};
    case (cls)
      3'd0: f.inst = enc_u(20'(rand_bits(20)), rd, OPC_LUI);
      3'd1: f.inst = enc_u(20'(rand_bits(20)), rd, OPC_AUIPC);
      3'd2: begin
        if (f3 == 3'b001) begin
          imm12 = {7'd0, imm12[4:0]};
        end else if (f3 == 3'b101) begin
          imm12 = {1'b0, alt, 5'd0, imm12[4:0]};
        end
        f.inst = enc_i(imm12, rs1, f3, rd, OPC_OP_IMM);
      end
      3'd3, 3'd4: begin
        f.inst = enc_r((((f3 == 3'b000) || (f3 == 3'b101)) && alt) ? 7'h20 : 7'h00,
                       rs2, rs1, f3, rd);
      end
      3'd5: begin
        if (alt) begin
          f.inst = enc_i(imm12, rs1, 3'b000, rd, OPC_JALR);
        end else begin
          f.inst = enc_j({20'(rand_bits(20)), 1'b0}, rd);
        end
      end
      3'd6: begin
        // funct3 010 and 011 are not branches.
        if (f3[2:1] == 2'b01) begin
          f3[2] = 1'b1;
        end
        f.inst = enc_b({imm12, 1'b0}, rs2, rs1, f3);
      end
      default: begin
        opc = 7'(rand_bits(7));
        while (is_slice_opcode(opc)) begin
          opc = 7'(rand_bits(7));
        end
        f.inst = {25'(rand_bits(25)), opc};
      end
    endcase
  endtask

  initial begin
    fetch_t f;
    rst        = 1'b1;
    in_valid_i = 1'b0;
    in_i       = '0;
    for (int r = 0; r < NUM_REGS; r++) begin
      model_rf[r] = '0;
    end
    repeat (5) @(posedge clk);
    rst        <= 1'b0;
    in_valid_i <= 1'b1;
    in_i       <= make_fetch(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM), 32'h0000_1000);
    @(negedge clk);
    compare_ready(1'b1);
    @(posedge clk);
    // x2 depends on x1 at distance one and goes through the forward port.
    in_i <= make_fetch(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2), 32'h0000_1004);
    @(negedge clk);
    compare_ready(1'b1);
    @(posedge clk);
    in_i <= make_fetch(enc_r(7'h00, 5'd0, 5'd1, 3'b000, 5'd3), 32'h0000_1008);
    @(negedge clk);
    compare_ready(1'b1);
    @(posedge clk);
    // distance two, x1 sits in writeback and decode holds for one cycle.
    in_valid_i <= 1'b0;
    @(negedge clk);
    compare_ready(1'b0);
    @(posedge clk);
    @(negedge clk);
    compare_ready(1'b1);
    @(posedge clk);
    drive_inst(make_fetch(enc_i(12'h123, 5'd0, 3'b000, 5'd0, OPC_OP_IMM), 32'h0000_100c));
    drive_inst(make_fetch(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd4), 32'h0000_1010));
    for (int i = 0; i < NUM_RANDOM; i++) begin
      if (2'(rand_bits(2)) == 2'd0) begin
        drive_idle();
      end
      gen_inst(f);
      drive_inst(f);
    end
    in_valid_i <= 1'b0;
    while (want_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    if (results_checked == NUM_TOTAL) begin
      $display("all tests passed");
      $finish;
    end else begin
      abort_run($sformatf("only %0d of %0d results arrived", results_checked, NUM_TOTAL));
    end
  end

endmodule

// ==== core_slice.f ====
hdl/rv_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/inst_decode.sv
hdl/alu_exec.sv
hdl/reg_writeback.sv
hdl/core_slice_top.sv
verif/core_slice_tb.sv

// ==== Makefile ====
TOP := core_slice_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f core_slice.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing -f core_slice.f --top-module $(TOP)
	verilator --lint-only hdl/rv_isa_pkg.sv hdl/pipe_pkg.sv hdl/inst_decode.sv \
		hdl/alu_exec.sv hdl/reg_writeback.sv hdl/core_slice_top.sv \
		--top-module core_slice_top

clean:
	rm -rf obj_dir
